// ==== alioth_pkg.sv ====
// alioth core shared definitions
package alioth_pkg;

    // datapath and register file sizes
    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_NUM        = 32;

    localparam int MUL_CYCLES = 32;  // one shift-add step per multiplier bit

    // major opcodes handled by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension marker

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]           reg_data_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASS_B  // lui result comes straight from operand b
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        ALU,
        MULDIV
    } dec_grp_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mul_state_e;

endpackage

// ==== cpu_top.sv ====
`timescale 1ns/1ps
// alioth execute slice top
module cpu_top
    import alioth_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    output logic        stall_o,
    output logic        illegal_o,
    output logic        wb_we_o,
    output reg_addr_t   wb_waddr_o,
    output reg_data_t   wb_wdata_o
);

    // idu outputs
    reg_addr_t idu_raddr1;
    reg_addr_t idu_raddr2;
    reg_addr_t idu_rd;
    logic      idu_rs1_used;
    logic      idu_rs2_used;
    logic      idu_rd_we;
    dec_grp_e  idu_grp;
    alu_op_e   idu_alu_op;
    reg_data_t idu_op_a;
    reg_data_t idu_op_b;
    reg_addr_t idu_ex_rd;
    logic      idu_ex_rd_we;

    reg_data_t gpr_rdata1;
    reg_data_t gpr_rdata2;
    reg_data_t alu_result;

    // multiplier to wbu
    logic      mul_valid;
    reg_addr_t mul_rd;
    reg_data_t mul_result;
    logic      mul_idle;
    logic      wbu_mul_ready;

    // decode info for hdu and the execute units
    wire is_mul    = (inst_i[6:0] == OPC_OP) && (inst_i[31:25] == FUNCT7_MULDIV) &&
                     (inst_i[14:12] == 3'b000);
    wire alu_valid = (idu_grp == ALU);
    wire mul_start = (idu_grp == MULDIV);

    idu u_idu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .stall_i     (stall_o),
        .rdata1_i    (gpr_rdata1),
        .rdata2_i    (gpr_rdata2),
        .raddr1_o    (idu_raddr1),
        .raddr2_o    (idu_raddr2),
        .rd_o        (idu_rd),
        .rs1_used_o  (idu_rs1_used),
        .rs2_used_o  (idu_rs2_used),
        .rd_we_o     (idu_rd_we),
        .grp_o       (idu_grp),
        .alu_op_o    (idu_alu_op),
        .op_a_o      (idu_op_a),
        .op_b_o      (idu_op_b),
        .ex_rd_o     (idu_ex_rd),
        .ex_rd_we_o  (idu_ex_rd_we),
        .illegal_o   (illegal_o)
    );

    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_we_o),
        .waddr_i (wb_waddr_o),
        .wdata_i (wb_wdata_o),
        .raddr1_i(idu_raddr1),
        .raddr2_i(idu_raddr2),
        .rdata1_o(gpr_rdata1),
        .rdata2_o(gpr_rdata2)
    );

    hdu u_hdu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(inst_valid_i),
        .rs1_i       (idu_raddr1),
        .rs2_i       (idu_raddr2),
        .rd_i        (idu_rd),
        .rs1_used_i  (idu_rs1_used),
        .rs2_used_i  (idu_rs2_used),
        .rd_we_i     (idu_rd_we),
        .is_mul_i    (is_mul),
        .mul_idle_i  (mul_idle),
        .wb_we_i     (wb_we_o),
        .wb_waddr_i  (wb_waddr_o),
        .stall_o     (stall_o)
    );

    exu_alu u_exu_alu (
        .alu_op_i(idu_alu_op),
        .op_a_i  (idu_op_a),
        .op_b_i  (idu_op_b),
        .result_o(alu_result)
    );

    exu_muldiv u_exu_muldiv (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (mul_start),
        .op_a_i  (idu_op_a),
        .op_b_i  (idu_op_b),
        .rd_i    (idu_ex_rd),
        .ready_i (wbu_mul_ready),
        .valid_o (mul_valid),
        .rd_o    (mul_rd),
        .result_o(mul_result),
        .idle_o  (mul_idle)
    );

    wbu u_wbu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .alu_valid_i (alu_valid),
        .alu_rd_i    (idu_ex_rd),
        .alu_we_i    (idu_ex_rd_we),
        .alu_result_i(alu_result),
        .mul_valid_i (mul_valid),
        .mul_rd_i    (mul_rd),
        .mul_result_i(mul_result),
        .mul_ready_o (wbu_mul_ready),
        .wb_we_o     (wb_we_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o)
    );

endmodule

// ==== exu_alu.sv ====
`timescale 1ns/1ps
// integer ALU
module exu_alu
    import alioth_pkg::*;
(
    input  alu_op_e   alu_op_i,
    input  reg_data_t op_a_i,
    input  reg_data_t op_b_i,
    output reg_data_t result_o
);

    logic [4:0] shamt;

    assign shamt = op_b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ADD:     result_o = op_a_i + op_b_i;
            SUB:     result_o = op_a_i - op_b_i;
            AND:     result_o = op_a_i & op_b_i;
            OR:      result_o = op_a_i | op_b_i;
            XOR:     result_o = op_a_i ^ op_b_i;
            SLL:     result_o = op_a_i << shamt;
            SRL:     result_o = op_a_i >> shamt;
            SRA:     result_o = reg_data_t'($signed(op_a_i) >>> shamt);
            SLT:     result_o = reg_data_t'($signed(op_a_i) < $signed(op_b_i));
            SLTU:    result_o = reg_data_t'(op_a_i < op_b_i);
            PASS_B:  result_o = op_b_i;  // lui
            default: result_o = '0;
        endcase
    end

endmodule

// ==== exu_muldiv.sv ====
`timescale 1ns/1ps
// iterative shift-add multiplier
module exu_muldiv
    import alioth_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      start_i,
    input  reg_data_t op_a_i,
    input  reg_data_t op_b_i,
    input  reg_addr_t rd_i,
    input  logic      ready_i,
    output logic      valid_o,
    output reg_addr_t rd_o,
    output reg_data_t result_o,
    output logic      idle_o
);

    mul_state_e                    state_q;
    logic [$clog2(MUL_CYCLES)-1:0] cnt_q;
    reg_data_t                     mcand_q;   // shifted left each step
    reg_data_t                     mplier_q;  // shifted right each step
    reg_data_t                     acc_q;
    logic                          last_step;

    assign last_step = (int'(cnt_q) == MUL_CYCLES - 1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (start_i) state_q <= BUSY;
                end
                BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) state_q <= DONE;
                end
                DONE:    if (ready_i) state_q <= IDLE;  // hold until wbu takes it
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            mcand_q  <= op_a_i;
            mplier_q <= op_b_i;
            acc_q    <= '0;
            rd_o     <= rd_i;
        end else if (state_q == BUSY) begin
            if (mplier_q[0]) acc_q <= acc_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign valid_o  = (state_q == DONE);
    assign result_o = acc_q;  // low 32 bits of the product
    assign idle_o   = (state_q == IDLE) && !start_i;  // a start in flight counts as busy

    // hdu must hold a second mul back until this one is gone
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |-> state_q == IDLE)
        else $error("multiplier started while not idle");

endmodule

// ==== filelist.f ====
alioth_pkg.sv
gpr.sv
idu.sv
hdu.sv
exu_alu.sv
exu_muldiv.sv
wbu.sv
cpu_top.sv
tb_cpu_top.sv

// ==== gpr.sv ====
`timescale 1ns/1ps
// general purpose register file
module gpr
    import alioth_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  reg_data_t wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output reg_data_t rdata1_o,
    output reg_data_t rdata2_o
);

    reg_data_t regs_q [REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // x0 stays zero
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // hdu keeps readers off pending registers so no bypass is needed
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// ==== hdu.sv ====
`timescale 1ns/1ps
// hazard detection scoreboard
module hdu
    import alioth_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      inst_valid_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      rs1_used_i,
    input  logic      rs2_used_i,
    input  logic      rd_we_i,
    input  logic      is_mul_i,
    input  logic      mul_idle_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_waddr_i,
    output logic      stall_o
);

    logic [REG_NUM-1:0] pending_q;  // one bit per register awaiting write-back
    logic               raw_hit;
    logic               waw_hit;
    logic               set_en;

    assign raw_hit = (rs1_used_i & pending_q[rs1_i]) | (rs2_used_i & pending_q[rs2_i]);
    assign waw_hit = rd_we_i & pending_q[rd_i];
    assign stall_o = inst_valid_i & (raw_hit | waw_hit | (is_mul_i & ~mul_idle_i));
    assign set_en  = inst_valid_i & ~stall_o & rd_we_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            if (wb_we_i) begin
                pending_q[wb_waddr_i] <= 1'b0;
            end
            if (set_en) begin
                pending_q[rd_i] <= 1'b1;  // x0 never gets here
            end
        end
    end

    // every commit from wbu must retire an instruction that was issued
    a_wb_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_we_i |-> pending_q[wb_waddr_i])
        else $error("write-back to register %0d with no pending bit", wb_waddr_i);

endmodule

// ==== idu.sv ====
`timescale 1ns/1ps
// instruction decode unit
module idu
    import alioth_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic        stall_i,
    input  reg_data_t   rdata1_i,
    input  reg_data_t   rdata2_i,
    output reg_addr_t   raddr1_o,
    output reg_addr_t   raddr2_o,
    output reg_addr_t   rd_o,
    output logic        rs1_used_o,
    output logic        rs2_used_o,
    output logic        rd_we_o,
    output dec_grp_e    grp_o,
    output alu_op_e     alu_op_o,
    output reg_data_t   op_a_o,
    output reg_data_t   op_b_o,
    output reg_addr_t   ex_rd_o,
    output logic        ex_rd_we_o,
    output logic        illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    logic       alt;      // selects sub / sra
    logic       is_m;
    logic       dec_ill;
    dec_grp_e   dec_grp;
    alu_op_e    dec_op;
    reg_data_t  dec_a;
    reg_data_t  dec_b;
    logic       accept;

    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);
    assign raddr1_o = inst_i[19:15];
    assign raddr2_o = inst_i[24:20];
    assign rd_o     = inst_i[11:7];
    assign accept   = inst_valid_i & ~stall_i;

    always_comb begin
        dec_ill = 1'b1;
        alt     = 1'b0;
        is_m    = 1'b0;
        dec_op  = ADD;
        dec_a   = rdata1_i;
        dec_b   = rdata2_i;
        case (opcode)
            OPC_LUI: begin
                dec_ill = 1'b0;
                dec_a   = '0;
                dec_b   = {inst_i[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                dec_b   = {{20{inst_i[31]}}, inst_i[31:20]};  // shamt sits in the low bits
                alt     = (funct3 == 3'b101) && f7_alt;
                dec_ill = ((funct3 == 3'b001) && !f7_zero) ||
                          ((funct3 == 3'b101) && !f7_zero && !f7_alt);
            end
            OPC_OP: begin
                is_m    = (funct7 == FUNCT7_MULDIV);
                alt     = f7_alt;
                // only mul is taken from the M extension
                dec_ill = !(f7_zero || (is_m && (funct3 == 3'b000)) ||
                            (f7_alt && ((funct3 == 3'b000) || (funct3 == 3'b101))));
            end
            default: ;
        endcase
        case (funct3)
            3'b000:  dec_op = alt ? SUB : ADD;
            3'b001:  dec_op = SLL;
            3'b010:  dec_op = SLT;
            3'b011:  dec_op = SLTU;
            3'b100:  dec_op = XOR;
            3'b101:  dec_op = alt ? SRA : SRL;
            3'b110:  dec_op = OR;
            default: dec_op = AND;
        endcase
        if (opcode == OPC_LUI) begin
            dec_op = PASS_B;
        end
    end

    assign dec_grp    = dec_ill ? NONE : (is_m ? MULDIV : ALU);
    assign rs1_used_o = !dec_ill && (opcode != OPC_LUI);
    assign rs2_used_o = !dec_ill && (opcode == OPC_OP);
    assign rd_we_o    = !dec_ill && (rd_o != '0);  // writes to x0 dropped here

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grp_o      <= NONE;
            ex_rd_we_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            grp_o      <= accept ? dec_grp : NONE;  // bubble when nothing taken
            ex_rd_we_o <= accept & rd_we_o;
            illegal_o  <= accept & dec_ill;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op_o <= dec_op;
            op_a_o   <= dec_a;
            op_b_o   <= dec_b;
            ex_rd_o  <= rd_o;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_top -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cpu_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== tb_cpu_top.sv ====
`timescale 1ns/1ps
// cpu_top directed testbench
module tb_cpu_top
    import alioth_pkg::*;
();

    localparam int WAIT_LIMIT = 200;  // cycles allowed for any single wait

    logic        clk;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        stall_o;
    logic        illegal_o;
    logic        wb_we_o;
    reg_addr_t   wb_waddr_o;
    reg_data_t   wb_wdata_o;

    reg_data_t   model_regs [REG_NUM];
    reg_addr_t   exp_rd_q [$];    // outstanding commits matched by rd
    reg_data_t   exp_data_q [$];
    reg_addr_t   commit_log [$];  // rd of every commit seen in order
    logic [15:0] lfsr_q = 16'd36847;
    logic        last_stall;
    int          illegal_cnt;
    int          hit_idx;
    int          check_cnt;
    int          mismatch_cnt;
    int          other_cnt;

    cpu_top cpu_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .stall_o     (stall_o),
        .illegal_o   (illegal_o),
        .wb_we_o     (wb_we_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // 16-bit galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb    = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (lsb) lfsr_q = lfsr_q ^ 16'hB400;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    // rv32i semantics for OP and OP-IMM by funct3
    function automatic reg_data_t calc_alu(input logic [2:0] f3, input logic alt,
                                           input reg_data_t a, input reg_data_t b);
        reg_data_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? reg_data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic int find_pending(input reg_addr_t rd);
        for (int i = 0; i < exp_rd_q.size(); i++) begin
            if (exp_rd_q[i] == rd) return i;
        end
        return -1;
    endfunction

    function automatic int log_index(input reg_addr_t rd);
        for (int i = 0; i < commit_log.size(); i++) begin
            if (commit_log[i] == rd) return i;
        end
        return -1;
    endfunction

    task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
        check_cnt++;
        if (exp !== act) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        check_cnt++;
        if (exp !== act) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_cnt++;
        if (exp !== act) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // hold the word until it is taken and note any stall in last_stall
    task automatic issue_inst(input string name, input logic [31:0] word);
        int cycles;
        cycles       = 0;
        last_stall   = 1'b0;
        inst_valid_i = 1'b1;
        inst_i       = word;
        @(negedge clk);
        while (stall_o && cycles < WAIT_LIMIT) begin
            last_stall = 1'b1;
            cycles++;
            @(negedge clk);
        end
        if (stall_o) begin
            other_cnt++;
            $display("%s: instruction still stalled after %0d cycles", name, cycles);
        end
        next_cycle();
        inst_valid_i = 1'b0;
    endtask

    task automatic expect_commit(input reg_addr_t rd, input reg_data_t val);
        if (rd != '0) begin  // x0 writes never commit
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(val);
            model_regs[rd] = val;
        end
    endtask

    task automatic exec_r(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        reg_data_t exp;
        exp = calc_alu(f3, f7[5], model_regs[rs1], model_regs[rs2]);
        issue_inst(name, {f7, rs2, rs1, f3, rd, OPC_OP});
        expect_commit(rd, exp);
    endtask

    task automatic exec_i(input string name, input logic [2:0] f3, input reg_addr_t rd,
                          input reg_addr_t rs1, input logic [11:0] imm);
        reg_data_t exp;
        exp = calc_alu(f3, (f3 == 3'b101) && imm[10], model_regs[rs1],
                       {{20{imm[11]}}, imm});
        issue_inst(name, {imm, rs1, f3, rd, OPC_OP_IMM});
        expect_commit(rd, exp);
    endtask

    task automatic exec_lui(input string name, input reg_addr_t rd, input logic [19:0] imm);
        issue_inst(name, {imm, rd, OPC_LUI});
        expect_commit(rd, {imm, 12'b0});
    endtask

    task automatic exec_mul(input string name, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2);
        logic [63:0] prod;
        prod = {32'b0, model_regs[rs1]} * {32'b0, model_regs[rs2]};
        issue_inst(name, {FUNCT7_MULDIV, rs2, rs1, 3'b000, rd, OPC_OP});
        expect_commit(rd, prod[31:0]);  // low half only
    endtask

    task automatic load_random(input string name, input reg_addr_t rd);
        logic [31:0] r;
        r = rand_bits(20);
        exec_lui(name, rd, r[19:0]);
        r = rand_bits(12);
        exec_i(name, 3'b000, rd, rd, r[11:0]);
    endtask

    task automatic wait_drain(input string name);
        int cycles;
        cycles = 0;
        while (exp_rd_q.size() != 0 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            other_cnt++;
            $display("%s: %0d commits never arrived", name, exp_rd_q.size());
        end
    endtask

    // every commit must match an outstanding instruction for that rd
    always @(negedge clk) begin
        if (rst_n_i && wb_we_o) begin
            hit_idx = find_pending(wb_waddr_o);
            if (hit_idx < 0) begin
                other_cnt++;
                $display("unexpected commit to x%0d with %h", wb_waddr_o, wb_wdata_o);
            end else begin
                check_data($sformatf("commit x%0d", wb_waddr_o), exp_data_q[hit_idx],
                           wb_wdata_o);
                exp_rd_q.delete(hit_idx);
                exp_data_q.delete(hit_idx);
            end
            commit_log.push_back(wb_waddr_o);
        end
        if (rst_n_i && illegal_o) illegal_cnt++;
    end

    task automatic test_load_const();
        logic [31:0] r;
        logic [11:0] imm;
        logic [19:0] up;
        r   = rand_bits(12);
        imm = r[11:0];
        exec_i("addi_const", 3'b000, 5'd1, 5'd0, imm);
        @(posedge clk);
        @(negedge clk);  // commit visible after the second edge
        check_flag("addi_const we", 1'b1, wb_we_o);
        check_addr("addi_const rd", 5'd1, wb_waddr_o);
        check_data("addi_const value", {{20{imm[11]}}, imm}, wb_wdata_o);
        next_cycle();
        r  = rand_bits(20);
        up = r[19:0];
        exec_lui("lui_const", 5'd2, up);
        @(posedge clk);
        @(negedge clk);
        check_flag("lui_const we", 1'b1, wb_we_o);
        check_addr("lui_const rd", 5'd2, wb_waddr_o);
        check_data("lui_const value", {up, 12'b0}, wb_wdata_o);
        @(negedge clk);
        check_flag("lui_const one cycle", 1'b0, wb_we_o);
        next_cycle();
        wait_drain("load_const");
    endtask

    task automatic test_alu_ops();
        logic [31:0] r;
        load_random("alu_src1", 5'd1);
        load_random("alu_src2", 5'd2);
        exec_r("add", 7'h00, 3'b000, 5'd5, 5'd1, 5'd2);
        exec_r("sub", 7'h20, 3'b000, 5'd6, 5'd1, 5'd2);
        exec_r("sll", 7'h00, 3'b001, 5'd7, 5'd1, 5'd2);
        exec_r("slt", 7'h00, 3'b010, 5'd8, 5'd1, 5'd2);
        exec_r("sltu", 7'h00, 3'b011, 5'd9, 5'd1, 5'd2);
        exec_r("xor", 7'h00, 3'b100, 5'd10, 5'd1, 5'd2);
        exec_r("srl", 7'h00, 3'b101, 5'd11, 5'd1, 5'd2);
        exec_r("sra", 7'h20, 3'b101, 5'd12, 5'd1, 5'd2);
        exec_r("or", 7'h00, 3'b110, 5'd13, 5'd1, 5'd2);
        exec_r("and", 7'h00, 3'b111, 5'd14, 5'd1, 5'd2);
        r = rand_bits(5);
        exec_i("slli", 3'b001, 5'd15, 5'd1, {7'h00, r[4:0]});
        r = rand_bits(5);
        exec_i("srli", 3'b101, 5'd16, 5'd2, {7'h00, r[4:0]});
        r = rand_bits(5);
        exec_i("srai", 3'b101, 5'd17, 5'd1, {7'h20, r[4:0]});
        r = rand_bits(12);
        exec_i("slti", 3'b010, 5'd18, 5'd2, r[11:0]);
        r = rand_bits(12);
        exec_i("sltiu", 3'b011, 5'd19, 5'd1, r[11:0]);
        r = rand_bits(12);
        exec_i("xori", 3'b100, 5'd20, 5'd2, r[11:0]);
        wait_drain("alu_ops");
    endtask

    task automatic test_x0();
        logic [31:0] r;
        r = rand_bits(12);
        exec_i("addi_to_x0", 3'b000, 5'd0, 5'd1, r[11:0]);
        exec_r("add_to_x0", 7'h00, 3'b000, 5'd0, 5'd1, 5'd2);
        exec_r("add_read_x0", 7'h00, 3'b000, 5'd5, 5'd0, 5'd1);
        exec_i("ori_read_x0", 3'b110, 5'd6, 5'd0, r[11:0]);
        wait_drain("x0");
    endtask

    task automatic test_dep_chain();
        logic [31:0] r;
        r = rand_bits(12);
        exec_i("chain_addi", 3'b000, 5'd21, 5'd1, r[11:0]);
        exec_r("chain_add", 7'h00, 3'b000, 5'd22, 5'd21, 5'd2);
        check_flag("chain_add stalled", 1'b1, last_stall);
        exec_r("chain_sub", 7'h20, 3'b000, 5'd23, 5'd22, 5'd21);
        exec_r("chain_xor", 7'h00, 3'b100, 5'd21, 5'd23, 5'd22);  // rewrites x21
        exec_i("chain_srai", 3'b101, 5'd24, 5'd21, {7'h20, 5'd3});
        wait_drain("dep_chain");
    endtask

    task automatic test_mul();
        load_random("mul_src1", 5'd3);
        load_random("mul_src2", 5'd4);
        wait_drain("mul_load");
        commit_log.delete();
        exec_mul("mul_first", 5'd25, 5'd3, 5'd4);
        exec_r("add_during_mul", 7'h00, 3'b000, 5'd26, 5'd1, 5'd2);
        exec_r("xor_during_mul", 7'h00, 3'b100, 5'd27, 5'd1, 5'd2);
        exec_i("andi_during_mul", 3'b111, 5'd28, 5'd2, 12'h5a3);
        exec_mul("mul_second", 5'd29, 5'd1, 5'd2);
        check_flag("mul_second stalled", 1'b1, last_stall);
        check_flag("mul_first before second", 1'b1, log_index(5'd25) >= 0);
        // alu stream still running when the second product is ready
        for (int i = 0; i < 40; i++) begin
            exec_r("add_stream", 7'h00, 3'b000, reg_addr_t'(26 + i % 3), 5'd1, 5'd2);
        end
        wait_drain("mul");
        check_flag("alu add first", 1'b1, log_index(5'd26) < log_index(5'd25));
        check_flag("alu xor first", 1'b1, log_index(5'd27) < log_index(5'd25));
        check_flag("alu andi first", 1'b1, log_index(5'd28) < log_index(5'd25));
        check_addr("mul_second after stream", 5'd29, commit_log[commit_log.size() - 1]);
    endtask

    task automatic test_illegal();
        int start_cnt;
        start_cnt = illegal_cnt;
        commit_log.delete();
        issue_inst("illegal_load", {12'h004, 5'd1, 3'b010, 5'd7, 7'b0000011});
        @(negedge clk);
        check_flag("illegal_load pulse", 1'b1, illegal_o);
        @(negedge clk);
        check_flag("illegal_load one cycle", 1'b0, illegal_o);
        next_cycle();
        // div is outside the kept M subset
        issue_inst("illegal_div", {FUNCT7_MULDIV, 5'd2, 5'd1, 3'b100, 5'd8, OPC_OP});
        repeat (5) next_cycle();
        check_flag("illegal pulse count", 1'b1, illegal_cnt == start_cnt + 2);
        check_flag("illegal no commit", 1'b1, commit_log.size() == 0);
    endtask

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        illegal_cnt  = 0;
        check_cnt    = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        last_stall   = 1'b0;
        for (int i = 0; i < REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_flag("reset stall", 1'b0, stall_o);
        check_flag("reset illegal", 1'b0, illegal_o);
        check_flag("reset commit", 1'b0, wb_we_o);
        test_load_const();
        test_alu_ops();
        test_x0();
        test_dep_chain();
        test_mul();
        test_illegal();
        wait_drain("final");
        repeat (3) next_cycle();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== wbu.sv ====
`timescale 1ns/1ps
// write-back unit
module wbu
    import alioth_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      alu_valid_i,
    input  reg_addr_t alu_rd_i,
    input  logic      alu_we_i,
    input  reg_data_t alu_result_i,
    input  logic      mul_valid_i,
    input  reg_addr_t mul_rd_i,
    input  reg_data_t mul_result_i,
    output logic      mul_ready_o,
    output logic      wb_we_o,
    output reg_addr_t wb_waddr_o,
    output reg_data_t wb_wdata_o
);

    logic alu_take;
    logic mul_take;

    assign alu_take    = alu_valid_i & alu_we_i;  // alu always has priority
    assign mul_ready_o = ~alu_take;
    assign mul_take    = mul_valid_i & mul_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= alu_take | (mul_take & (mul_rd_i != '0));
        end
    end

    always_ff @(posedge clk) begin
        if (alu_take) begin
            wb_waddr_o <= alu_rd_i;
            wb_wdata_o <= alu_result_i;
        end else if (mul_take) begin
            wb_waddr_o <= mul_rd_i;
            wb_wdata_o <= mul_result_i;
        end
    end

    // a product held back by an alu result stays on offer
    a_mul_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        mul_valid_i && alu_take |=>
            mul_valid_i && $stable(mul_rd_i) && $stable(mul_result_i))
        else $error("multiplier result dropped while an alu result held the slot");

endmodule
